/* rtl/raster_pkg.sv */
package raster_pkg;

    // #########################################################################
    // bus, record and queue sizes
    // #########################################################################

    localparam int bus_addr_width = 26;         // byte address, word aligned
    localparam int word_bytes = 4;

    localparam int triangle_vertices = 3;
    localparam int vertex_words = 4;            // x, y, z, w
    localparam int colour_words = 3;
    localparam int record_words = triangle_vertices * vertex_words + colour_words;
    localparam int record_index_width = $clog2(record_words);

    localparam int fifo_depth = 4;              // whole triangle records
    localparam int fifo_pointer_width = $clog2(fifo_depth);
    localparam int slot_count_width = $clog2(fifo_depth + 1);

    localparam int screen_width = 640;
    localparam int screen_height = 480;

    // #########################################################################
    // read bus
    // #########################################################################

    typedef struct packed {
        logic [bus_addr_width-1:0] address;
        logic read;
    } bus_request_t;

    typedef struct packed {
        logic [31:0] readdata;
        logic readdatavalid;
        logic waitrequest;
    } bus_response_t;

    // #########################################################################
    // geometry
    // #########################################################################

    typedef logic signed [31:0] fixed_t;        // 16.16

    typedef struct packed {
        fixed_t x;
        fixed_t y;
        fixed_t z;
        fixed_t w;
    } vertex_t;

    typedef struct packed {
        vertex_t [triangle_vertices-1:0] vertex;
        logic [colour_words-1:0][31:0] colour;
        logic last;                             // final triangle of the job
    } triangle_t;

    typedef struct packed {
        logic [15:0] min_x;
        logic [15:0] max_x;
        logic [15:0] min_y;
        logic [15:0] max_y;
        logic signed [31:0] area2;
        logic [31:0] colour;
    } setup_result_t;

endpackage

/* rtl/vertex_fetch.sv */
`timescale 1ns/1ps

module vertex_fetch import raster_pkg::*; (
    input  logic clock,
    input  logic reset,
    input  logic fetch_enable,
    input  logic [bus_addr_width-1:0] vertex_buffer_base,
    input  bus_response_t bus_response,
    input  logic [slot_count_width-1:0] free_slots,
    output bus_request_t bus_request,
    output triangle_t record,
    output logic record_valid
);

    typedef enum logic [2:0] {
        req_idle,
        req_count,          // count word on the bus
        req_wait_count,     // until the count has come back
        req_next,           // between records, waits for a free slot
        req_record
    } req_state_t;

    typedef enum logic [1:0] {
        rx_idle,
        rx_count,
        rx_record
    } rx_state_t;

    req_state_t req_state;
    rx_state_t rx_state;

    logic [record_index_width-1:0] req_word;
    logic [record_index_width-1:0] rx_word;
    logic [31:0] triangle_count;
    logic [31:0] triangles_requested;
    logic [31:0] triangles_received;
    logic [slot_count_width-1:0] in_flight;    // records requested, not yet pushed
    logic [31:0] word_buf [record_words];
    logic record_last;

    logic start_job;
    logic accepted;
    logic credit_ok;
    logic start_record;
    logic last_word_in;

    assign start_job = fetch_enable && req_state == req_idle && rx_state == rx_idle;
    assign accepted = bus_request.read && !bus_response.waitrequest;
    assign credit_ok = in_flight < free_slots;
    assign start_record = req_state == req_next && triangles_requested != triangle_count
                          && credit_ok;
    assign last_word_in = rx_state == rx_record && bus_response.readdatavalid
                          && rx_word == record_index_width'(record_words - 1);

    // #########################################################################
    // request side
    // #########################################################################

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            req_state <= req_idle;
            bus_request.read <= 1'b0;
            bus_request.address <= '0;
            req_word <= '0;
            triangles_requested <= '0;
        end else begin
            case (req_state)
                req_idle: begin
                    if (start_job) begin
                        bus_request.address <= vertex_buffer_base;
                        bus_request.read <= 1'b1;
                        triangles_requested <= '0;
                        req_state <= req_count;
                    end
                end
                req_count: begin
                    if (accepted) begin
                        bus_request.read <= 1'b0;
                        bus_request.address <= bus_request.address + bus_addr_width'(word_bytes);
                        req_state <= req_wait_count;
                    end
                end
                req_wait_count: begin
                    if (rx_state == rx_record)
                        req_state <= req_next;
                end
                req_next: begin
                    if (triangles_requested == triangle_count) begin
                        req_state <= req_idle;
                    end else if (start_record) begin
                        bus_request.read <= 1'b1;   // address already points at the record
                        req_word <= '0;
                        req_state <= req_record;
                    end
                end
                req_record: begin
                    if (accepted) begin
                        bus_request.address <= bus_request.address + bus_addr_width'(word_bytes);
                        if (req_word == record_index_width'(record_words - 1)) begin
                            bus_request.read <= 1'b0;
                            triangles_requested <= triangles_requested + 1;
                            req_state <= req_next;
                        end else begin
                            req_word <= req_word + 1'b1;
                        end
                    end
                end
                default: req_state <= req_idle;
            endcase
        end
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            in_flight <= '0;
        end else begin
            case ({start_record, record_valid})
                2'b10: in_flight <= in_flight + 1'b1;
                2'b01: in_flight <= in_flight - 1'b1;
                default: in_flight <= in_flight;
            endcase
        end
    end

    // #########################################################################
    // receive side
    // #########################################################################

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            rx_state <= rx_idle;
            rx_word <= '0;
            triangle_count <= '0;
            triangles_received <= '0;
            record_valid <= 1'b0;
            record_last <= 1'b0;
        end else begin
            record_valid <= last_word_in;
            case (rx_state)
                rx_idle: begin
                    if (start_job)
                        rx_state <= rx_count;
                end
                rx_count: begin
                    if (bus_response.readdatavalid) begin
                        triangle_count <= bus_response.readdata;
                        triangles_received <= '0;
                        rx_word <= '0;
                        rx_state <= rx_record;
                    end
                end
                rx_record: begin
                    if (last_word_in) begin
                        rx_word <= '0;
                        triangles_received <= triangles_received + 1;
                        record_last <= triangles_received + 1 == triangle_count;
                        if (triangles_received + 1 == triangle_count)
                            rx_state <= rx_idle;
                    end else if (bus_response.readdatavalid) begin
                        rx_word <= rx_word + 1'b1;
                    end
                end
                default: rx_state <= rx_idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (rx_state == rx_record && bus_response.readdatavalid)
            word_buf[rx_word] <= bus_response.readdata;
    end

    // words arrive as x, y, z, w per vertex, then the colours
    always_comb begin
        for (int v = 0; v < triangle_vertices; v++) begin
            record.vertex[v].x = word_buf[v * vertex_words];
            record.vertex[v].y = word_buf[v * vertex_words + 1];
            record.vertex[v].z = word_buf[v * vertex_words + 2];
            record.vertex[v].w = word_buf[v * vertex_words + 3];
        end
        for (int c = 0; c < colour_words; c++)
            record.colour[c] = word_buf[triangle_vertices * vertex_words + c];
        record.last = record_last;
    end

endmodule

/* rtl/triangle_fifo.sv */
`timescale 1ns/1ps

module triangle_fifo import raster_pkg::*; (
    input  logic clock,
    input  logic reset,
    input  logic push,
    input  triangle_t push_record,
    input  logic pop,
    output triangle_t head,
    output logic not_empty,
    output logic [slot_count_width-1:0] free_slots
);

    triangle_t slots [fifo_depth];
    logic [fifo_pointer_width-1:0] write_ptr;
    logic [fifo_pointer_width-1:0] read_ptr;
    logic [slot_count_width-1:0] occupancy;
    logic do_pop;

    function automatic logic [fifo_pointer_width-1:0] next_ptr(
        input logic [fifo_pointer_width-1:0] ptr
    );
        if (ptr == fifo_pointer_width'(fifo_depth - 1))
            return '0;
        return ptr + 1'b1;
    endfunction

    assign do_pop = pop && not_empty;

    always_ff @(posedge clock) begin
        if (push)
            slots[write_ptr] <= push_record;
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            write_ptr <= '0;
            read_ptr <= '0;
            occupancy <= '0;
        end else begin
            if (push)
                write_ptr <= next_ptr(write_ptr);
            if (do_pop)
                read_ptr <= next_ptr(read_ptr);
            case ({push, do_pop})
                2'b10: occupancy <= occupancy + 1'b1;
                2'b01: occupancy <= occupancy - 1'b1;
                default: occupancy <= occupancy;
            endcase
        end
    end

    assign head = slots[read_ptr];          // show-ahead
    assign not_empty = occupancy != '0;
    assign free_slots = slot_count_width'(fifo_depth) - occupancy;

endmodule

/* rtl/triangle_setup.sv */
`timescale 1ns/1ps

module triangle_setup import raster_pkg::*; (
    input  logic clock,
    input  logic reset,
    input  triangle_t head,
    input  logic not_empty,
    input  logic stall,
    output logic pop,
    output setup_result_t result,
    output logic result_valid,
    output logic done
);

    typedef struct packed {
        logic signed [15:0] min_x;
        logic signed [15:0] max_x;
        logic signed [15:0] min_y;
        logic signed [15:0] max_y;
        logic signed [16:0] edge1_x;    // v1 - v0
        logic signed [16:0] edge1_y;
        logic signed [16:0] edge2_x;    // v2 - v0
        logic signed [16:0] edge2_y;
        logic [31:0] colour;
        logic last;
    } stage1_t;

    function automatic logic signed [15:0] min3(
        input logic signed [15:0] a,
        input logic signed [15:0] b,
        input logic signed [15:0] c
    );
        logic signed [15:0] m;
        m = (a < b) ? a : b;
        return (m < c) ? m : c;
    endfunction

    function automatic logic signed [15:0] max3(
        input logic signed [15:0] a,
        input logic signed [15:0] b,
        input logic signed [15:0] c
    );
        logic signed [15:0] m;
        m = (a > b) ? a : b;
        return (m > c) ? m : c;
    endfunction

    logic signed [15:0] px [triangle_vertices];
    logic signed [15:0] py [triangle_vertices];
    stage1_t s1_next;
    stage1_t s1;
    logic s1_valid;

    logic signed [34:0] area_full;
    logic signed [15:0] box_min_x;
    logic signed [15:0] box_max_x;
    logic signed [15:0] box_min_y;
    logic signed [15:0] box_max_y;
    logic keep;
    logic s2_last;

    assign pop = not_empty && !stall;

    // #########################################################################
    // stage 1: integer pixel positions, raw box, edges
    // #########################################################################

    always_comb begin
        for (int i = 0; i < triangle_vertices; i++) begin
            px[i] = head.vertex[i].x[31:16];    // drop the fraction
            py[i] = head.vertex[i].y[31:16];
        end
        s1_next.min_x = min3(px[0], px[1], px[2]);
        s1_next.max_x = max3(px[0], px[1], px[2]);
        s1_next.min_y = min3(py[0], py[1], py[2]);
        s1_next.max_y = max3(py[0], py[1], py[2]);
        s1_next.edge1_x = px[1] - px[0];
        s1_next.edge1_y = py[1] - py[0];
        s1_next.edge2_x = px[2] - px[0];
        s1_next.edge2_y = py[2] - py[0];
        s1_next.colour = head.colour[0];
        s1_next.last = head.last;
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset)
            s1_valid <= 1'b0;
        else if (!stall)
            s1_valid <= pop;
    end

    always_ff @(posedge clock) begin
        if (pop)
            s1 <= s1_next;
    end

    // #########################################################################
    // stage 2: clamp, area, cull
    // #########################################################################

    // only the near side of each bound is clamped, so an off-screen box ends up empty
    always_comb begin
        area_full = s1.edge1_x * s1.edge2_y - s1.edge2_x * s1.edge1_y;
        box_min_x = (s1.min_x < 0) ? 16'sd0 : s1.min_x;
        box_min_y = (s1.min_y < 0) ? 16'sd0 : s1.min_y;
        box_max_x = (s1.max_x > 16'(screen_width - 1)) ? 16'(screen_width - 1) : s1.max_x;
        box_max_y = (s1.max_y > 16'(screen_height - 1)) ? 16'(screen_height - 1) : s1.max_y;
        keep = area_full != 0 && box_min_x <= box_max_x && box_min_y <= box_max_y;
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            result_valid <= 1'b0;
            s2_last <= 1'b0;
        end else if (!stall) begin
            result_valid <= s1_valid && keep;
            s2_last <= s1_valid && s1.last;     // culled or not
        end
    end

    always_ff @(posedge clock) begin
        if (!stall && s1_valid && keep) begin
            result.min_x <= box_min_x;
            result.max_x <= box_max_x;
            result.min_y <= box_min_y;
            result.max_y <= box_max_y;
            result.area2 <= area_full[31:0];
            result.colour <= s1.colour;
        end
    end

    // stage 2 hands its record on in a cycle without stall
    assign done = s2_last && !stall;

endmodule

/* rtl/raster_front.sv */
`timescale 1ns/1ps

module raster_front import raster_pkg::*; (
    input  logic clock,
    input  logic reset,
    input  logic fetch_enable,
    input  logic [bus_addr_width-1:0] vertex_buffer_base,
    input  bus_response_t bus_response,
    input  logic stall,
    output bus_request_t bus_request,
    output setup_result_t result,
    output logic result_valid,
    output logic done
);

    triangle_t record;
    logic record_valid;
    logic [slot_count_width-1:0] free_slots;
    triangle_t head;
    logic not_empty;
    logic pop;

    // #########################################################################
    // fetch -> queue -> setup
    // #########################################################################

    vertex_fetch fetch0 (
        .clock              (clock),
        .reset              (reset),
        .fetch_enable       (fetch_enable),
        .vertex_buffer_base (vertex_buffer_base),
        .bus_response       (bus_response),
        .free_slots         (free_slots),
        .bus_request        (bus_request),
        .record             (record),
        .record_valid       (record_valid)
    );

    triangle_fifo fifo0 (
        .clock       (clock),
        .reset       (reset),
        .push        (record_valid),
        .push_record (record),
        .pop         (pop),
        .head        (head),
        .not_empty   (not_empty),
        .free_slots  (free_slots)
    );

    triangle_setup setup0 (
        .clock        (clock),
        .reset        (reset),
        .head         (head),
        .not_empty    (not_empty),
        .stall        (stall),
        .pop          (pop),
        .result       (result),
        .result_valid (result_valid),
        .done         (done)
    );

endmodule

/* verification/bus_memory_model.sv */
`timescale 1ns/1ps

module bus_memory_model import raster_pkg::*; #(
    parameter int seed_value = 1,
    parameter int memory_words = 128
) (
    input  logic clock,
    input  logic reset,
    input  bus_request_t bus_request,
    output bus_response_t bus_response,
    output logic read_error
);

    logic [31:0] memory [memory_words];
    logic [31:0] pending [$];                   // accepted reads, oldest first
    logic [bus_addr_width-1:0] held_address;
    logic [bus_addr_width-1:0] expected_address;
    logic hold_pending;
    logic accepted;
    integer seed;
    int base_address;
    int job_reads;                              // count word plus all record words
    int read_index;

    initial begin
        seed = seed_value;
        $readmemh("verification/raster_front_golden.txt", memory);
        base_address = memory[0];
        job_reads = 1 + record_words * memory[base_address / word_bytes];
    end

    function automatic logic [31:0] read_word(input logic [bus_addr_width-1:0] address);
        if (address / word_bytes < memory_words)
            return memory[address / word_bytes];
        return 32'hbad0_0000 ^ 32'(address);    // outside the image
    endfunction

    assign accepted = bus_request.read && !bus_response.waitrequest;
    assign expected_address = bus_addr_width'(base_address + word_bytes * read_index);

    always @(posedge clock or negedge reset) begin
        if (!reset) begin
            pending.delete();
            bus_response <= '0;
            read_error <= 1'b0;
            read_index <= 0;
            hold_pending <= 1'b0;
            held_address <= '0;
        end else begin
            if (hold_pending && (!bus_request.read || bus_request.address != held_address)) begin
                $display("CHECK FAILED at %0t: bus_request.address got %h expected %h, read %b",
                         $time, bus_request.address, held_address, bus_request.read);
                read_error <= 1'b1;
            end
            hold_pending <= bus_request.read && bus_response.waitrequest;
            held_address <= bus_request.address;

            // return before taking the new read, so data lags acceptance by a cycle or more
            if (pending.size() != 0 && ($random(seed) & 3) != 0) begin
                bus_response.readdata <= pending.pop_front();
                bus_response.readdatavalid <= 1'b1;
            end else begin
                bus_response.readdatavalid <= 1'b0;
            end

            if (accepted) begin
                if (bus_request.address != expected_address) begin
                    $display("CHECK FAILED at %0t: bus_request.address got %h expected %h",
                             $time, bus_request.address, expected_address);
                    read_error <= 1'b1;
                end
                pending.push_back(read_word(bus_request.address));
                read_index <= (read_index + 1 == job_reads) ? 0 : read_index + 1;
            end

            bus_response.waitrequest <= ($random(seed) & 3) == 0;
        end
    end

endmodule

/* verification/raster_front_tb.sv */
`timescale 1ns/1ps

module raster_front_tb import raster_pkg::*; ();

    localparam int random_seed = 62339;
    localparam int golden_words = 128;
    localparam int result_offset = 8;           // first expected result word
    localparam int max_kept = 8;
    localparam int job_count = 2;
    localparam int stall_burst = 200;           // cycles of stall at each job start

    logic clock;
    logic reset;
    logic fetch_enable;
    logic [bus_addr_width-1:0] vertex_buffer_base;
    logic stall = 1'b0;
    bus_response_t bus_response;
    bus_request_t bus_request;
    setup_result_t result;
    logic result_valid;
    logic done;
    logic read_error;

    logic [31:0] golden [golden_words];
    setup_result_t expected_results [max_kept];
    setup_result_t held_result;
    logic held_valid = 1'b0;
    logic done_seen = 1'b0;
    logic checking = 1'b0;
    int kept_count;
    int results_seen = 0;
    int stall_hold = 0;
    int cycle_count = 0;
    int cycle_limit;
    integer seed = random_seed;

    raster_front dut0 (
        .clock              (clock),
        .reset              (reset),
        .fetch_enable       (fetch_enable),
        .vertex_buffer_base (vertex_buffer_base),
        .bus_response       (bus_response),
        .stall              (stall),
        .bus_request        (bus_request),
        .result             (result),
        .result_valid       (result_valid),
        .done               (done)
    );

    bus_memory_model #(.seed_value(random_seed)) memory0 (
        .clock        (clock),
        .reset        (reset),
        .bus_request  (bus_request),
        .bus_response (bus_response),
        .read_error   (read_error)
    );

    // #########################################################################
    // checks
    // #########################################################################

    task automatic stop_run();
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic compare_bit(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, expected);
            stop_run();
        end
    endtask

    task automatic compare_result(input string name, input setup_result_t got,
                                  input setup_result_t expected);
        if (got !== expected) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, expected);
            stop_run();
        end
    endtask

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout, the run did not finish within %0d cycles", cycle_limit);
            stop_run();
        end
    end

    // a long stall at each job start fills the FIFO and halts fetch on credit
    always @(posedge clock) begin
        if (reset) begin
            if (stall_hold != 0) begin
                stall <= 1'b1;
                stall_hold <= stall_hold - 1;
            end else if (fetch_enable) begin
                stall <= 1'b1;
                stall_hold <= stall_burst;
            end else begin
                stall <= ($random(seed) & 7) < 3;
            end
        end
    end

    // outputs are sampled on the falling edge and a result counts only where stall is low
    always @(negedge clock) begin
        if (checking) begin
            if (read_error) begin
                $display("the bus model saw a read out of sequence");
                stop_run();
            end
            if (held_valid) begin
                compare_bit("result_valid", result_valid, 1'b1);
                compare_result("result", result, held_result);
            end
            held_valid = result_valid && stall;
            held_result = result;
            if (result_valid && !stall) begin
                if (results_seen >= kept_count)
                    compare_bit("result_valid", result_valid, 1'b0);
                compare_result("result", result, expected_results[results_seen]);
                results_seen++;
            end
            if (done) begin
                if (done_seen)
                    compare_bit("done", done, 1'b0);
                if (results_seen != kept_count) begin
                    $display("done came after %0d of %0d results", results_seen, kept_count);
                    stop_run();
                end
                done_seen = 1'b1;
            end
        end
    end

    // #########################################################################
    // stimulus
    // #########################################################################

    task automatic run_job(input logic [bus_addr_width-1:0] base);
        results_seen = 0;
        done_seen = 1'b0;
        @(posedge clock);
        fetch_enable <= 1'b1;
        vertex_buffer_base <= base;
        @(posedge clock);
        fetch_enable <= 1'b0;
        wait (done_seen);
        repeat (30) @(posedge clock);           // quiet window after done
    endtask

    initial begin
        reset = 1'b0;
        fetch_enable = 1'b0;
        vertex_buffer_base = '0;
        $readmemh("verification/raster_front_golden.txt", golden);
        kept_count = golden[1];
        for (int i = 0; i < kept_count; i++) begin
            expected_results[i] = {golden[result_offset + 4 * i],
                                   golden[result_offset + 4 * i + 1],
                                   golden[result_offset + 4 * i + 2],
                                   golden[result_offset + 4 * i + 3]};
        end
        cycle_limit = 200 * job_count * (1 + record_words * golden[golden[0] / word_bytes])
                      + job_count * stall_burst + 500;

        repeat (10) @(posedge clock);
        reset <= 1'b1;
        checking = 1'b1;
        repeat (5) begin
            @(negedge clock);
            compare_bit("bus_request.read", bus_request.read, 1'b0);
            compare_bit("result_valid", result_valid, 1'b0);
            compare_bit("done", done, 1'b0);
        end

        for (int job = 0; job < job_count; job++)
            run_job(golden[0][bus_addr_width-1:0]);

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

/* verification/raster_front_golden.txt */
// @00 base byte address, kept count; @08 expected results as
// {min_x max_x} {min_y max_y} area2 colour; @20 memory image, count then x y z w x3, colours
@00
00000080 00000004
@08
000A0064 001400C8 00003DB8 FF0000FF
00C80190 0064012C FFFF7748 00FF00FF
0000027F 000001DF 0005AD20 0000FFFF
0258027F 019001D6 FFFFF61E 80808080
@20
00000006
// kept, first x is 10.5
000A8000 00140000 00010000 00010000 00640000 001E0000 00010000 00010000
00320000 00C80000 00010000 00010000 FF0000FF 11111111 22222222
// degenerate, all three on one line
00000000 00000000 00010000 00010000 000A0000 000A0000 00010000 00010000
00140000 00140000 00010000 00010000 0000FF00 33333333 44444444
// kept, negative area
012C0000 00640000 00020000 00010000 00C80000 00FA0000 00020000 00010000
01900000 012C0000 00020000 00010000 00FF00FF 55555555 66666666
// right of the screen
02BC0000 000A0000 00010000 00010000 03200000 000A0000 00010000 00010000
02EE0000 00640000 00010000 00010000 12345678 77777777 88888888
// partly off screen, clamped on all sides
FFCE0000 FFEC0000 00030000 00010000 02BC0000 00640000 00030000 00010000
00640000 01F40000 00030000 00010000 0000FFFF 99999999 AAAAAAAA
// last of the job
02580000 01900000 00010000 00010000 026C0000 01D60000 00010000 00010000
027F0000 019A0000 00010000 00010000 80808080 BBBBBBBB CCCCCCCC

/* sources.f */
rtl/raster_pkg.sv
rtl/vertex_fetch.sv
rtl/triangle_fifo.sv
rtl/triangle_setup.sv
rtl/raster_front.sv
verification/bus_memory_model.sv
verification/raster_front_tb.sv

/* Bender.yml */
package:
  name: raster_front

sources:
  - rtl/raster_pkg.sv
  - rtl/vertex_fetch.sv
  - rtl/triangle_fifo.sv
  - rtl/triangle_setup.sv
  - rtl/raster_front.sv
  - target: simulation
    files:
      - verification/bus_memory_model.sv
      - verification/raster_front_tb.sv
